/* hw/smc_pkg.sv */
// Controller structs, APB register map and AHB encodings
`default_nettype none

package smc_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int WAIT_W = 4;   // Wait-state field width
  localparam int CNT_W  = 16;  // Completed access counter width

  // --------------------
  // AHB encodings
  // --------------------
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  // Low two bits of hsize
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;

  // --------------------
  // APB register map
  // --------------------
  localparam logic [4:0] REG_CTRL   = 5'h00;  // Bit 0 enable
  localparam logic [4:0] REG_TIMING = 5'h04;  // Read and write wait states
  localparam logic [4:0] REG_COUNT  = 5'h08;  // Access count, read only

  localparam int CTRL_EN_BIT = 0;   // Enable position in CTRL
  localparam int RD_WAIT_LSB = 0;   // rd_wait at TIMING[3:0]
  localparam int WR_WAIT_LSB = 8;   // wr_wait at TIMING[11:8]

  // Configuration from the register block
  typedef struct packed {
    logic              enable;   // Controller enabled
    logic [WAIT_W-1:0] rd_wait;  // Read strobe is rd_wait+1 cycles
    logic [WAIT_W-1:0] wr_wait;  // Write strobe is wr_wait+1 cycles
  } smc_cfg_t;

  // One captured AHB address phase
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [1:0]  size;   // hsize[1:0]
  } smc_req_t;

endpackage

`default_nettype wire

/* hw/smc_apb_regs.sv */
// APB register block with enable, read and write wait states and access counter
`timescale 1ns/1ps
`default_nettype none

module smc_apb_regs (
  input  wire                     hclk,
  input  wire                     rst_n,
  input  wire                     psel,
  input  wire                     penable,
  input  wire                     pwrite,
  input  wire  [4:0]              paddr,
  input  wire  [31:0]             pwdata,
  input  wire                     done,     // Access completed in sequencer
  output logic [31:0]             prdata,
  output smc_pkg::smc_cfg_t       cfg
);

  logic                        wr_en;     // APB access phase write
  logic [smc_pkg::CNT_W-1:0]   acc_cnt;   // Completed accesses, wraps

  assign wr_en = psel & penable & pwrite;

  // --------------------
  // Register writes
  // --------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      cfg     <= '0;  // Disabled, minimum strobes
      acc_cnt <= '0;
    end else begin
      if (wr_en && paddr == smc_pkg::REG_CTRL) begin
        cfg.enable <= pwdata[smc_pkg::CTRL_EN_BIT];
      end
      if (wr_en && paddr == smc_pkg::REG_TIMING) begin
        cfg.rd_wait <= pwdata[smc_pkg::RD_WAIT_LSB +: smc_pkg::WAIT_W];
        cfg.wr_wait <= pwdata[smc_pkg::WR_WAIT_LSB +: smc_pkg::WAIT_W];
      end
      // COUNT is read only, writes fall through
      if (done) begin
        acc_cnt <= acc_cnt + 1'b1;  // Wraps at 2^16
      end
    end
  end

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    prdata = '0;  // Undefined bits and offsets read zero
    case (paddr)
      smc_pkg::REG_CTRL: begin
        prdata[smc_pkg::CTRL_EN_BIT] = cfg.enable;
      end
      smc_pkg::REG_TIMING: begin
        prdata[smc_pkg::RD_WAIT_LSB +: smc_pkg::WAIT_W] = cfg.rd_wait;
        prdata[smc_pkg::WR_WAIT_LSB +: smc_pkg::WAIT_W] = cfg.wr_wait;
      end
      smc_pkg::REG_COUNT: begin
        prdata[smc_pkg::CNT_W-1:0] = acc_cnt;
      end
      default: begin
        prdata = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/smc_ahb_slave.sv */
// AHB-lite slave front end with address capture, error response and stretched data phase
`timescale 1ns/1ps
`default_nettype none

module smc_ahb_slave (
  input  wire                  hclk,
  input  wire                  rst_n,
  input  wire  [31:0]          haddr,
  input  wire  [1:0]           htrans,
  input  wire                  hsel,
  input  wire                  hwrite,
  input  wire  [2:0]           hsize,
  input  wire  [31:0]          hwdata,
  input  wire                  hready,     // Muxed bus ready
  input  wire                  enable,     // CTRL enable bit
  input  wire                  done,       // Sequencer hold cycle
  input  wire  [31:0]          rdata,      // Sequencer read data
  output logic [31:0]          smc_hrdata,
  output logic                 smc_hready,
  output logic [1:0]           smc_hresp,
  output logic                 smc_valid,
  output smc_pkg::smc_req_t    req,
  output logic                 start,      // One cycle, first data cycle
  output logic [31:0]          wdata
);

  logic accept;     // Address phase taken this edge
  logic bad;        // Transfer gets ERROR
  logic err_first;  // First of the two ERROR cycles

  // --------------------
  // Address phase decode
  // --------------------
  assign accept = hsel & hready &
                  (htrans == smc_pkg::HTRANS_NONSEQ | htrans == smc_pkg::HTRANS_SEQ);

  always_comb begin
    bad = ~enable;                            // Disabled controller
    if (hsize[2] || hsize[1:0] == 2'b11) begin
      bad = 1'b1;                             // Wider than a word
    end
    if (hsize[1:0] == smc_pkg::SIZE_HALF && haddr[0]) begin
      bad = 1'b1;                             // Odd halfword
    end
    if (hsize[1:0] == smc_pkg::SIZE_WORD && haddr[1:0] != 2'b00) begin
      bad = 1'b1;                             // Unaligned word
    end
  end

  // --------------------
  // Response control
  // --------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      smc_hready <= 1'b1;
      smc_hresp  <= smc_pkg::HRESP_OKAY;
      start      <= 1'b0;
      err_first  <= 1'b0;
    end else begin
      start     <= 1'b0;   // Pulses only
      err_first <= 1'b0;
      if (accept) begin
        smc_hready <= 1'b0;                    // Stretch data phase
        if (bad) begin
          smc_hresp <= smc_pkg::HRESP_ERROR;
          err_first <= 1'b1;
        end else begin
          smc_hresp <= smc_pkg::HRESP_OKAY;
          start     <= 1'b1;                   // Kick sequencer
        end
      end else if (err_first) begin
        smc_hready <= 1'b1;                    // Second ERROR cycle
      end else if (done) begin
        smc_hready <= 1'b1;                    // Data phase ends next cycle
      end else if (smc_hready) begin
        smc_hresp <= smc_pkg::HRESP_OKAY;      // Back to idle response
      end
    end
  end

  assign smc_valid = start;  // Cycle 0 of an OKAY access

  // Payload, no reset needed
  always_ff @(posedge hclk) begin
    if (accept) begin
      req.addr  <= haddr;
      req.write <= hwrite;
      req.size  <= hsize[1:0];
    end
    if (start) begin
      wdata <= hwdata;         // hwdata valid in first data cycle
    end
    if (done) begin
      smc_hrdata <= rdata;     // Read word for the final cycle
    end
  end

endmodule

`default_nettype wire

/* hw/smc_access_seq.sv */
// External access sequencer with wait counting, byte-lane decode and memory strobes
`timescale 1ns/1ps
`default_nettype none

module smc_access_seq (
  input  wire                  hclk,
  input  wire                  rst_n,
  input  wire  smc_pkg::smc_req_t req,       // Held stable by the slave
  input  wire                  start,
  input  wire  [31:0]          wdata,
  input  wire  smc_pkg::smc_cfg_t cfg,
  input  wire  [31:0]          data_smc,   // External read data
  output logic                 done,
  output logic [31:0]          rdata,
  output logic [31:0]          smc_addr,
  output logic [31:0]          smc_data,
  output logic [3:0]           smc_n_be,
  output logic                 smc_n_cs,
  output logic [3:0]           smc_n_we,
  output logic                 smc_n_wr,
  output logic                 smc_n_rd,
  output logic                 smc_n_ext_oe,
  output logic                 smc_busy
);

  typedef enum logic [1:0] {
    S_IDLE,   // Waiting for start
    S_ADDR,   // Address setup, chip select low
    S_STRB,   // Read or write strobe low
    S_HOLD    // Hold, strobes released
  } seq_state_t;

  seq_state_t                   state;
  logic [smc_pkg::WAIT_W-1:0]   wait_cnt;   // Remaining strobe cycles minus one
  logic                         strobe;     // In strobe phase
  logic                         last;       // Final strobe cycle
  logic [3:0]                   be_n;       // Lane enables, active low

  assign strobe = (state == S_STRB);
  assign last   = strobe && (wait_cnt == '0);

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_ADDR;
          end
        end
        S_ADDR: begin
          // Load wait count for this direction
          wait_cnt <= req.write ? cfg.wr_wait : cfg.rd_wait;
          state    <= S_STRB;
        end
        S_STRB: begin
          if (wait_cnt == '0) begin
            state <= S_HOLD;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        S_HOLD: begin
          state <= S_IDLE;   // One hold cycle only
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Read word captured at the end of the strobe
  always_ff @(posedge hclk) begin
    if (last && !req.write) begin
      rdata <= data_smc;
    end
  end

  // --------------------
  // Byte-lane decode
  // --------------------
  always_comb begin
    case (req.size)
      smc_pkg::SIZE_BYTE: begin
        be_n = ~(4'b0001 << req.addr[1:0]);          // One lane
      end
      smc_pkg::SIZE_HALF: begin
        be_n = req.addr[1] ? 4'b0011 : 4'b1100;      // Upper or lower pair
      end
      default: begin
        be_n = 4'b0000;                              // Full word
      end
    endcase
  end

  // --------------------
  // Memory pins
  // --------------------
  assign done     = (state == S_HOLD);
  assign smc_busy = (state != S_IDLE);
  assign smc_n_cs = ~smc_busy;                      // Address, strobe and hold

  assign smc_n_rd = ~(strobe & ~req.write);
  assign smc_n_wr = ~(strobe & req.write);
  assign smc_n_we = be_n | {4{smc_n_wr}};           // Per-lane write strobes
  assign smc_n_be = smc_busy ? be_n : 4'hf;         // Released when idle

  // Drive the data bus from strobe through hold of writes
  assign smc_n_ext_oe = ~(req.write & (strobe | done));

  assign smc_addr = req.addr;
  assign smc_data = wdata;

endmodule

`default_nettype wire

/* hw/smc_top.sv */
// Static memory controller top with AHB slave, access sequencer and APB registers
`timescale 1ns/1ps
`default_nettype none

module smc_top (
  // Clock and reset
  input  wire         hclk,
  input  wire         rst_n,
  // AHB-lite slave
  input  wire  [31:0] haddr,
  input  wire  [1:0]  htrans,
  input  wire         hsel,
  input  wire         hwrite,
  input  wire  [2:0]  hsize,
  input  wire  [31:0] hwdata,
  input  wire         hready,
  output wire  [31:0] smc_hrdata,
  output wire         smc_hready,
  output wire  [1:0]  smc_hresp,
  output wire         smc_valid,
  // APB configuration
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [4:0]  paddr,
  input  wire  [31:0] pwdata,
  output wire  [31:0] prdata,
  // External memory
  output wire  [31:0] smc_addr,
  output wire  [31:0] smc_data,
  input  wire  [31:0] data_smc,
  output wire  [3:0]  smc_n_be,
  output wire         smc_n_cs,
  output wire  [3:0]  smc_n_we,
  output wire         smc_n_wr,
  output wire         smc_n_rd,
  output wire         smc_n_ext_oe,
  // Status
  output wire         smc_busy
);

  smc_pkg::smc_cfg_t cfg;     // Register outputs
  smc_pkg::smc_req_t req;     // Captured address phase
  logic              start;
  logic              done;
  logic [31:0]       wdata;
  logic [31:0]       rdata;

  // --------------------
  // Instances
  // --------------------
  smc_apb_regs u_regs (
    .hclk    (hclk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .done    (done),
    .prdata  (prdata),
    .cfg     (cfg)
  );

  smc_ahb_slave u_slave (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .haddr      (haddr),
    .htrans     (htrans),
    .hsel       (hsel),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hwdata     (hwdata),
    .hready     (hready),
    .enable     (cfg.enable),   // Only the enable bit
    .done       (done),
    .rdata      (rdata),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .smc_valid  (smc_valid),
    .req        (req),
    .start      (start),
    .wdata      (wdata)
  );

  smc_access_seq u_seq (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .req          (req),
    .start        (start),
    .wdata        (wdata),
    .cfg          (cfg),
    .data_smc     (data_smc),
    .done         (done),
    .rdata        (rdata),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_we     (smc_n_we),
    .smc_n_wr     (smc_n_wr),
    .smc_n_rd     (smc_n_rd),
    .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy     (smc_busy)
  );

endmodule

`default_nettype wire

/* verif/smc_mem_model.sv */
// Behavioral asynchronous SRAM with byte write strobes and an address-dependent fill
`timescale 1ns/1ps
`default_nettype none

module smc_mem_model (
  input  wire  [31:0] addr,
  input  wire  [31:0] wr_data,
  input  wire  [3:0]  n_be,     // Lane enables, active low
  input  wire         n_cs,
  input  wire  [3:0]  n_we,     // Per-lane write strobes
  input  wire         n_rd,
  output logic [31:0] rd_data
);

  logic [31:0] mem [0:255];     // 1 KB, word index addr[9:2]
  logic [3:0]  we_q = 4'hf;     // Last seen write strobes

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h96, i[7:0] + 8'h3c};  // Unique per word
    end
  end

  // Lane written at the rising end of its strobe
  always @(n_we) begin
    for (int i = 0; i < 4; i++) begin
      if (we_q[i] === 1'b0 && n_we[i] === 1'b1 && n_cs === 1'b0) begin
        mem[addr[9:2]][8*i +: 8] = wr_data[8*i +: 8];
      end
    end
    we_q = n_we;
  end

  // Disabled lanes read back zero
  always_comb begin
    rd_data = '0;
    if (!n_cs && !n_rd) begin
      for (int i = 0; i < 4; i++) begin
        rd_data[8*i +: 8] = n_be[i] ? 8'h00 : mem[addr[9:2]][8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_smc.sv */
// Testbench for the memory controller with AHB and APB drivers, shadow memory and assertions
`timescale 1ns/1ps
`default_nettype none

module tb_smc;

  localparam int TMO = 64;  // Cycles allowed for one response

  logic        hclk = 1'b0;
  logic        rst_n = 1'b0;
  logic [31:0] haddr = '0;
  logic [1:0]  htrans = 2'b00;
  logic        hsel = 1'b0;
  logic        hwrite = 1'b0;
  logic [2:0]  hsize = 3'd0;
  logic [31:0] hwdata = '0;
  logic        hready = 1'b1;   // Single slave, follows smc_hready
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [4:0]  paddr = '0;
  logic [31:0] pwdata = '0;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  logic [1:0]  smc_hresp;
  logic        smc_valid;
  logic [31:0] prdata;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [31:0] data_smc;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic [3:0]  smc_n_we;
  logic        smc_n_wr;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  int          n_val_err = 0;
  int          n_proto_err = 0;
  int          ok_cnt = 0;       // OKAY transfers since reset
  logic [7:0]  shadow [0:1023];  // Predicted memory bytes
  logic [3:0]  exp_rd = '0;      // Programmed wait states
  logic [3:0]  exp_wr = '0;
  logic [3:0]  exp_be = 4'hf;    // Lanes of the access in flight
  logic        in_err = 1'b0;    // Error transfer open
  logic [4:0]  rd_len = '0;      // Cycles of the current read strobe
  logic [4:0]  wr_len = '0;
  logic        strb;

  assign strb = ~smc_n_rd | ~smc_n_wr;

  smc_top u_dut (.*);

  smc_mem_model u_mem (
    .addr    (smc_addr),
    .wr_data (smc_data),
    .n_be    (smc_n_be),
    .n_cs    (smc_n_cs),
    .n_we    (smc_n_we),
    .n_rd    (smc_n_rd),
    .rd_data (data_smc)
  );

  initial begin
    forever #20 hclk = ~hclk;
  end

  always @(negedge hclk) hready <= smc_hready;

  always @(posedge hclk) begin
    rd_len <= smc_n_rd ? 5'd0 : rd_len + 5'd1;
    wr_len <= (&smc_n_we) ? 5'd0 : wr_len + 5'd1;
  end

  // --------------------
  // Assertions
  // --------------------
  a_rd_width: assert property (@(posedge hclk) disable iff (!rst_n)
    $rose(smc_n_rd) |-> rd_len == {1'b0, exp_rd} + 5'd1)
    else begin
      $display("ERR smc_n_rd width %h exp %h", $sampled(rd_len), $sampled(exp_rd) + 5'd1);
      n_val_err++;
    end
  a_wr_width: assert property (@(posedge hclk) disable iff (!rst_n)
    $rose(&smc_n_we) |-> wr_len == {1'b0, exp_wr} + 5'd1)
    else begin
      $display("ERR smc_n_we width %h exp %h", $sampled(wr_len), $sampled(exp_wr) + 5'd1);
      n_val_err++;
    end
  a_setup: assert property (@(posedge hclk) disable iff (!rst_n)
    $fell(smc_n_cs) |-> !strb ##1 strb)
    else begin
      $display("chip select not low for exactly one cycle before the strobe");
      n_proto_err++;
    end
  a_hold: assert property (@(posedge hclk) disable iff (!rst_n)
    $fell(strb) |-> !smc_n_cs ##1 (smc_n_cs && !smc_busy))
    else begin
      $display("chip select or busy not released one cycle after the strobe");
      n_proto_err++;
    end
  a_lanes: assert property (@(posedge hclk) disable iff (!rst_n)
    !smc_n_cs |-> smc_n_be == exp_be)
    else begin
      $display("ERR smc_n_be %h exp %h", $sampled(smc_n_be), $sampled(exp_be));
      n_val_err++;
    end
  // Data bus driven from the write strobe through hold
  a_oe_wr: assert property (@(posedge hclk) disable iff (!rst_n)
    (!smc_n_wr || $rose(&smc_n_we)) |-> !smc_n_ext_oe)
    else begin
      $display("data bus not driven during the write strobe and hold");
      n_proto_err++;
    end
  a_oe_rd: assert property (@(posedge hclk) disable iff (!rst_n)
    (smc_n_cs || !smc_n_rd) |-> smc_n_ext_oe)
    else begin
      $display("data bus driven outside a write access");
      n_proto_err++;
    end
  a_err_seq: assert property (@(posedge hclk) disable iff (!rst_n)
    (smc_hresp == smc_pkg::HRESP_ERROR && !smc_hready) |=>
    (smc_hresp == smc_pkg::HRESP_ERROR && smc_hready))
    else begin
      $display("second ERROR cycle missing after the first");
      n_proto_err++;
    end
  a_err_quiet: assert property (@(posedge hclk) disable iff (!rst_n) in_err |-> smc_n_cs)
    else begin
      $display("external bus selected during an error transfer");
      n_proto_err++;
    end
  a_valid: assert property (@(posedge hclk) disable iff (!rst_n)
    smc_valid |=> !smc_valid && !smc_n_cs && smc_busy)
    else begin
      $display("smc_valid not a single pulse ahead of the address cycle");
      n_proto_err++;
    end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s %h exp %h", name, got, exp);
      n_val_err++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol", n_val_err, n_proto_err);
    if (n_val_err == 0 && n_proto_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // Lanes covered by a naturally aligned transfer, active low
  function automatic logic [3:0] lane_be(input logic [2:0] size, input logic [1:0] off);
    int n;
    int lo;
    n  = 1 << size;
    lo = off & ~(n - 1);
    for (int i = 0; i < 4; i++) begin
      lane_be[i] = !(i >= lo && i < lo + n);
    end
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return {shadow[{addr[9:2], 2'd3}], shadow[{addr[9:2], 2'd2}],
            shadow[{addr[9:2], 2'd1}], shadow[{addr[9:2], 2'd0}]};
  endfunction

  task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] data,
                          output logic [31:0] rd);
    @(negedge hclk);
    psel   = 1'b1;
    pwrite = wr;
    paddr  = addr;
    pwdata = data;
    @(negedge hclk);
    penable = 1'b1;  // Access phase
    @(negedge hclk);
    rd      = prdata;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic set_timing(input logic [3:0] rd, input logic [3:0] wr);
    logic [31:0] unused;
    apb_xfer(1'b1, smc_pkg::REG_TIMING, {20'h0, wr, 4'h0, rd}, unused);
    exp_rd = rd;
    exp_wr = wr;
  endtask

  task automatic ahb_xfer(input logic wr, input logic [2:0] size, input logic [31:0] addr,
                          input logic [31:0] data, input logic bad);
    int          t;
    logic [31:0] exp_rdata;
    exp_rdata = word_at(addr);
    @(negedge hclk);
    haddr  = addr;
    htrans = smc_pkg::HTRANS_NONSEQ;
    hsel   = 1'b1;
    hwrite = wr;
    hsize  = size;
    exp_be = lane_be(size, addr[1:0]);
    in_err = bad;
    @(negedge hclk);   // Cycle 0 of the data phase
    htrans = 2'b00;
    hsel   = 1'b0;
    hwdata = data;
    check_val("smc_hready", smc_hready, 32'h0);
    check_val("smc_hresp", smc_hresp, bad ? smc_pkg::HRESP_ERROR : smc_pkg::HRESP_OKAY);
    check_val("smc_valid", smc_valid, {31'h0, !bad});
    t = 0;
    while (smc_hready !== 1'b1 && t < TMO) begin
      @(negedge hclk);
      t++;
    end
    if (smc_hready !== 1'b1) begin
      $display("no AHB response within %0d cycles at address %h", TMO, addr);
      n_proto_err++;
      finish_run();
    end else begin
      check_val("smc_hresp", smc_hresp, bad ? smc_pkg::HRESP_ERROR : smc_pkg::HRESP_OKAY);
      if (!bad && !wr) check_val("smc_hrdata", smc_hrdata, exp_rdata);
      if (!bad) begin
        ok_cnt++;
        for (int i = 0; i < 4; i++) begin
          if (wr && !exp_be[i]) shadow[{addr[9:2], 2'(i)}] = data[8*i +: 8];
        end
      end
      @(negedge hclk);
      in_err = 1'b0;
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] addrs [4];
    void'($urandom(32'h8449_6b27));
    repeat (8) @(posedge hclk);
    @(negedge hclk);
    rst_n = 1'b1;

    // Idle state after reset
    @(negedge hclk);
    check_val("smc_hready", smc_hready, 32'h1);
    check_val("smc_hresp", smc_hresp, smc_pkg::HRESP_OKAY);
    check_val("smc_n_cs", smc_n_cs, 32'h1);
    check_val("smc_n_rd", smc_n_rd, 32'h1);
    check_val("smc_n_wr", smc_n_wr, 32'h1);
    check_val("smc_n_we", smc_n_we, 32'hf);
    check_val("smc_n_be", smc_n_be, 32'hf);
    check_val("smc_n_ext_oe", smc_n_ext_oe, 32'h1);
    check_val("smc_busy", smc_busy, 32'h0);
    check_val("smc_valid", smc_valid, 32'h0);
    apb_xfer(1'b0, smc_pkg::REG_CTRL, 32'h0, r);
    check_val("prdata", r, 32'h0);

    // Register readback, undefined bits dropped
    repeat (4) begin
      d = $urandom();
      apb_xfer(1'b1, smc_pkg::REG_CTRL, d, r);
      apb_xfer(1'b0, smc_pkg::REG_CTRL, 32'h0, r);
      check_val("prdata", r, {31'h0, d[0]});
      d = $urandom();
      apb_xfer(1'b1, smc_pkg::REG_TIMING, d, r);
      apb_xfer(1'b0, smc_pkg::REG_TIMING, 32'h0, r);
      check_val("prdata", r, d & 32'h0000_0f0f);
    end
    apb_xfer(1'b0, smc_pkg::REG_COUNT, 32'h0, d);
    apb_xfer(1'b1, smc_pkg::REG_COUNT, ~d, r);
    apb_xfer(1'b0, smc_pkg::REG_COUNT, 32'h0, r);
    check_val("prdata", r, d);

    // Word writes then reads under random wait states
    apb_xfer(1'b1, smc_pkg::REG_CTRL, 32'h1, r);
    repeat (3) begin
      set_timing(4'($urandom()), 4'($urandom()));
      for (int i = 0; i < 4; i++) begin
        addrs[i] = $urandom() & 32'hffff_fffc;
        ahb_xfer(1'b1, {1'b0, smc_pkg::SIZE_WORD}, addrs[i], $urandom(), 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
        ahb_xfer(1'b0, {1'b0, smc_pkg::SIZE_WORD}, addrs[i], 32'h0, 1'b0);
      end
    end

    // Byte and halfword lanes at every legal offset
    for (int s = 0; s < 2; s++) begin
      for (int off = 0; off < 4; off += s + 1) begin
        a = $urandom() & 32'hffff_fffc;
        ahb_xfer(1'b1, {1'b0, smc_pkg::SIZE_WORD}, a, $urandom(), 1'b0);
        ahb_xfer(1'b1, 3'(s), a | 32'(off), $urandom(), 1'b0);
        ahb_xfer(1'b0, {1'b0, smc_pkg::SIZE_WORD}, a, 32'h0, 1'b0);
      end
    end

    // Error responses leave count and memory alone
    apb_xfer(1'b0, smc_pkg::REG_COUNT, 32'h0, d);
    apb_xfer(1'b1, smc_pkg::REG_CTRL, 32'h0, r);
    ahb_xfer(1'b1, {1'b0, smc_pkg::SIZE_WORD}, a, $urandom(), 1'b1);
    ahb_xfer(1'b0, {1'b0, smc_pkg::SIZE_BYTE}, a, 32'h0, 1'b1);
    apb_xfer(1'b1, smc_pkg::REG_CTRL, 32'h1, r);
    ahb_xfer(1'b1, {1'b0, smc_pkg::SIZE_HALF}, a | 32'h1, $urandom(), 1'b1);
    ahb_xfer(1'b0, {1'b0, smc_pkg::SIZE_WORD}, a | 32'h2, 32'h0, 1'b1);
    ahb_xfer(1'b1, {1'b0, smc_pkg::SIZE_WORD}, a | 32'h1, $urandom(), 1'b1);
    ahb_xfer(1'b0, 3'd3, a, 32'h0, 1'b1);  // Doubleword
    apb_xfer(1'b0, smc_pkg::REG_COUNT, 32'h0, r);
    check_val("prdata", r, d);
    ahb_xfer(1'b0, {1'b0, smc_pkg::SIZE_WORD}, a, 32'h0, 1'b0);

    // Completed access count
    apb_xfer(1'b0, smc_pkg::REG_COUNT, 32'h0, r);
    check_val("prdata", r, 32'(ok_cnt % 65536));
    finish_run();
  end

endmodule

`default_nettype wire

/* files.f */
hw/smc_pkg.sv
hw/smc_apb_regs.sv
hw/smc_ahb_slave.sv
hw/smc_access_seq.sv
hw/smc_top.sv
verif/smc_mem_model.sv
verif/tb_smc.sv
